/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= tb.f
TOP        ?= tb_l1_tag
RTL_TOP    ?= l1_tag_top
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	rm -f $(LOG)
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST) --top-module $(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_l1_tag.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_l1_tag;

	import l1_tag_pkg::*;

	localparam int NUM_SETS = 16;
	localparam int ADDR_WIDTH = 26;
	localparam int SET_WIDTH = $clog2(NUM_SETS);
	localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH;
	localparam int APB_TIMEOUT = 16;
	localparam int RUN_LIMIT = 40000;
	// Lookups and fills draw from a pool of eight tags so that hits are common
	localparam logic [TAG_WIDTH-1:0] TAG_BASE = 22'h15a00;

	logic clk;
	logic reset;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	logic [7:0] paddr_i;
	logic [31:0] pwdata_i;
	logic [31:0] prdata_o;
	logic pready_o;
	logic pslverr_o;
	logic lookup_valid_i;
	logic [ADDR_WIDTH-1:0] lookup_addr_i;
	logic hit_o;
	logic [WAY_WIDTH-1:0] hit_way_o;

	// Prediction for the lookup on the bus, and the same one a cycle later
	logic exp_hit;
	logic [WAY_WIDTH-1:0] exp_way;
	logic exp_hit_q;
	logic [WAY_WIDTH-1:0] exp_way_q;

	// Expected APB response of the transfer on the bus
	logic exp_err;
	logic [31:0] exp_rdata;

	// Reference model of the tag and valid state
	logic [TAG_WIDTH-1:0] model_tag [NUM_SETS][NUM_WAYS];
	logic model_valid [NUM_SETS][NUM_WAYS];

	l1_tag_top #(
		.NUM_SETS(NUM_SETS),
		.ADDR_WIDTH(ADDR_WIDTH)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.lookup_valid_i(lookup_valid_i),
		.lookup_addr_i(lookup_addr_i),
		.hit_o(hit_o),
		.hit_way_o(hit_way_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// A cycle without a lookup must be followed by a miss
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			exp_hit_q <= 1'b0;
			exp_way_q <= '0;
		end
		else
		begin
			exp_hit_q <= lookup_valid_i && exp_hit;
			exp_way_q <= exp_way;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("error %s got 0x%h expected 0x%h", name, got, want);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	a_hit: assert property (@(posedge clk) disable iff (reset) hit_o == exp_hit_q)
		else report_mismatch("hit_o", 32'($sampled(hit_o)), 32'($sampled(exp_hit_q)));

	a_hit_way: assert property (@(posedge clk) disable iff (reset)
		hit_o |-> hit_way_o == exp_way_q)
		else report_mismatch("hit_way_o", 32'($sampled(hit_way_o)), 32'($sampled(exp_way_q)));

	// The error flag may only show in the access phase
	a_slverr: assert property (@(posedge clk) disable iff (reset)
		pslverr_o == (psel_i && penable_i && exp_err))
		else report_mismatch("pslverr_o", 32'($sampled(pslverr_o)),
			32'($sampled(psel_i && penable_i && exp_err)));

	a_rdata: assert property (@(posedge clk) disable iff (reset)
		(psel_i && penable_i && !pwrite_i) |-> prdata_o == exp_rdata)
		else report_mismatch("prdata_o", $sampled(prdata_o), $sampled(exp_rdata));

	function automatic logic [TAG_WIDTH-1:0] pool_tag(input int k);
		return TAG_BASE + TAG_WIDTH'(k);
	endfunction

	// Picks a pool tag that no other valid way of the set holds
	function automatic logic [TAG_WIDTH-1:0] free_tag(input int s, input int w, input int start);
		logic [TAG_WIDTH-1:0] cand;
		logic used;
		cand = pool_tag(start);
		for (int i = 0; i < 8; i++)
		begin
			cand = pool_tag((start + i) % 8);
			used = 1'b0;
			for (int v = 0; v < NUM_WAYS; v++)
				if (v != w && model_valid[s][v] && model_tag[s][v] == cand)
					used = 1'b1;
			if (!used)
				return cand;
		end
		return cand;
	endfunction

	// Setup phase, then access phase held until pready
	task automatic apb_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] data, input logic err, input logic [31:0] rdata);
		int waited;
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = write;
		paddr_i = addr;
		pwdata_i = data;
		exp_err = err;
		exp_rdata = rdata;
		@(posedge clk);
		#1;
		penable_i = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!pready_o)
		begin
			waited++;
			if (waited > APB_TIMEOUT)
				report_failure("APB transfer saw no pready within the timeout");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic err);
		apb_transfer(1'b1, addr, data, err, 32'h0);
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [31:0] rdata, input logic err);
		apb_transfer(1'b0, addr, 32'h0, err, rdata);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// Programs one command and updates the model when the storage takes it
	task automatic run_cmd(input tag_cmd_e op, input int s, input int w,
		input logic [TAG_WIDTH-1:0] tag);
		apb_write(REG_TAG, 32'(tag), 1'b0);
		apb_write(REG_LOC, (32'(w) << 16) | 32'(s), 1'b0);
		apb_write(REG_CMD, 32'(op), 1'b0);
		// The pulse is out in this cycle and is written at the next edge
		@(posedge clk);
		#1;
		case (op)
			CMD_FILL:
			begin
				model_tag[s][w] = tag;
				model_valid[s][w] = 1'b1;
			end
			CMD_INV_WAY: model_valid[s][w] = 1'b0;
			CMD_INV_SET:
				for (int v = 0; v < NUM_WAYS; v++)
					model_valid[s][v] = 1'b0;
			default: ;
		endcase
	endtask

	task automatic lookup(input int s, input logic [TAG_WIDTH-1:0] tag);
		exp_hit = 1'b0;
		exp_way = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (model_valid[s][w] && model_tag[s][w] == tag)
			begin
				exp_hit = 1'b1;
				exp_way = WAY_WIDTH'(w);
			end
		end
		lookup_valid_i = 1'b1;
		lookup_addr_i = {tag, SET_WIDTH'(s)};
		@(posedge clk);
		#1;
		lookup_valid_i = 1'b0;
	endtask

	task automatic sweep_set(input int s);
		for (int k = 0; k < 8; k++)
			lookup(s, pool_tag(k));
	endtask

	task automatic random_ops(input int count);
		int op;
		int s;
		int w;
		for (int n = 0; n < count; n++)
		begin
			op = $urandom_range(9);
			s = $urandom_range(NUM_SETS - 1);
			w = $urandom_range(NUM_WAYS - 1);
			if (op < 3)
				run_cmd(CMD_FILL, s, w, free_tag(s, w, $urandom_range(7)));
			else if (op < 5)
				run_cmd(CMD_INV_WAY, s, w, pool_tag(0));
			else if (op == 5)
				run_cmd(CMD_INV_SET, s, w, pool_tag(0));
			else
				lookup(s, pool_tag($urandom_range(7)));
		end
	endtask

	// Bounds the whole run in case a task never returns
	initial
	begin
		int cycles;
		cycles = 0;
		while (cycles < RUN_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		report_failure("simulation did not finish within the cycle limit");
	end

	initial
	begin
		void'($urandom(43968));
		reset = 1'b1;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		lookup_valid_i = 1'b0;
		lookup_addr_i = '0;
		exp_hit = 1'b0;
		exp_way = '0;
		exp_err = 1'b0;
		exp_rdata = '0;
		for (int s = 0; s < NUM_SETS; s++)
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				model_tag[s][w] = '0;
				model_valid[s][w] = 1'b0;
			end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		idle(2);

		// Everything misses after reset, and idle cycles stay quiet
		for (int s = 0; s < NUM_SETS; s++)
			lookup(s, pool_tag(s % 8));
		idle(4);

		// Single fill, then the same tag, another tag and another set
		run_cmd(CMD_FILL, 5, 2, pool_tag(3));
		lookup(5, pool_tag(3));
		lookup(5, pool_tag(4));
		lookup(6, pool_tag(3));

		// Full set, then one way dropped
		for (int w = 0; w < NUM_WAYS; w++)
			run_cmd(CMD_FILL, 9, w, pool_tag(w));
		sweep_set(9);
		run_cmd(CMD_INV_WAY, 9, 1, pool_tag(0));
		sweep_set(9);

		// Set invalidate next to a filled neighbour
		for (int w = 0; w < NUM_WAYS; w++)
			run_cmd(CMD_FILL, 10, w, pool_tag(4 + w));
		run_cmd(CMD_FILL, 11, 0, pool_tag(4));
		run_cmd(CMD_INV_SET, 10, 0, pool_tag(0));
		sweep_set(10);
		sweep_set(11);

		// Register readback and the three error cases
		// The location points at the filled way of set 5, so a rejected
		// set invalidate that slipped through would show in the sweep
		apb_write(REG_TAG, 32'h002a_b1c3, 1'b0);
		apb_read(REG_TAG, 32'h002a_b1c3, 1'b0);
		apb_write(REG_LOC, 32'h0002_0005, 1'b0);
		apb_read(REG_LOC, 32'h0002_0005, 1'b0);
		apb_read(REG_CMD, 32'h0, 1'b0);
		apb_write(8'h18, 32'(CMD_INV_SET), 1'b1);
		apb_read(8'h0c, 32'h0, 1'b1);
		apb_write(REG_CMD, 32'h0, 1'b1);
		apb_write(REG_LOC, 32'h0001_0010, 1'b1);
		apb_read(REG_LOC, 32'h0002_0005, 1'b0);
		idle(2);
		sweep_set(5);
		sweep_set(9);
		sweep_set(11);
		sweep_set(12);

		random_ops(300);
		idle(2);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* src/cache_valid_array.sv */
`default_nettype none
`timescale 1ns/1ns

module cache_valid_array #(
	parameter int NUM_SETS = 16,
	localparam int SET_WIDTH = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1
) (
	input logic clk,
	input logic reset,
	input logic rd_en_i,
	input logic [SET_WIDTH-1:0] rd_addr_i,
	output logic rd_valid_o,
	input logic wr_en_i,
	input logic [SET_WIDTH-1:0] wr_addr_i,
	input logic wr_valid_i
);

	// One valid bit per set
	// These live in flops rather than a RAM so that reset can clear every
	// line at once without a sweep through the sets
	logic [NUM_SETS-1:0] valid_q;

	// Write port
	// A fill sets the bit, an invalidate clears it
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			valid_q <= '0;
		end
		else if (wr_en_i)
		begin
			valid_q[wr_addr_i] <= wr_valid_i;
		end
	end

	// Registered read, matching the one cycle latency of the tag RAM
	// The old bit is sampled on a same-cycle write to the same set,
	// which keeps it aligned with the read-first tag RAM next to it
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rd_valid_o <= 1'b0;
		end
		else if (rd_en_i)
		begin
			rd_valid_o <= valid_q[rd_addr_i];
		end
	end

endmodule

`default_nettype wire

/* src/l1_cache_tag.sv */
`default_nettype none
`timescale 1ns/1ns

module l1_cache_tag #(
	parameter int NUM_SETS = l1_tag_pkg::DEF_NUM_SETS,
	parameter int ADDR_WIDTH = l1_tag_pkg::DEF_ADDR_WIDTH,
	localparam int SET_WIDTH = $clog2(NUM_SETS),
	localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH
) (
	input logic clk,
	input logic reset,

	// Lookup request
	input logic access_i,
	input logic [ADDR_WIDTH-1:0] request_addr_i,

	// Lookup response, one cycle after the request
	output logic cache_hit_o,
	output logic [l1_tag_pkg::WAY_WIDTH-1:0] hit_way_o,

	// Update commands from the APB slave
	input logic update_i,
	input logic inv_way_i,
	input logic inv_set_i,
	input logic [l1_tag_pkg::WAY_WIDTH-1:0] update_way_i,
	input logic [TAG_WIDTH-1:0] update_tag_i,
	input logic [SET_WIDTH-1:0] update_set_i
);

	import l1_tag_pkg::*;

	// Split of the request address
	// Low bits pick the set, the rest is compared against the stored tag
	logic [SET_WIDTH-1:0] req_set;
	logic [TAG_WIDTH-1:0] req_tag;

	// Request state held for the compare in the response cycle
	logic access_q;
	logic [TAG_WIDTH-1:0] req_tag_q;

	// Per-way signals
	logic [NUM_WAYS-1:0] way_wr_en;
	logic [NUM_WAYS-1:0] way_valid;
	logic [NUM_WAYS-1:0] way_hit;
	logic [TAG_WIDTH-1:0] way_tag [NUM_WAYS];

	assign req_set = request_addr_i[SET_WIDTH-1:0];
	assign req_tag = request_addr_i[ADDR_WIDTH-1:SET_WIDTH];

	// All four ways are read in parallel with the same set index
	for (genvar w = 0; w < NUM_WAYS; w++)
	begin : g_way
		// A fill or a single-way invalidate touches only the selected way
		// A set invalidate touches every way of the set
		assign way_wr_en[w] = ((update_i || inv_way_i) && (update_way_i == WAY_WIDTH'(w)))
			|| inv_set_i;

		// The tag itself only changes on a fill
		sram_1r1w #(
			.WIDTH(TAG_WIDTH),
			.DEPTH(NUM_SETS)
		) tag_mem (
			.clk(clk),
			.reset(reset),
			.rd_en_i(access_i),
			.rd_addr_i(req_set),
			.rd_data_o(way_tag[w]),
			.wr_en_i(way_wr_en[w] && update_i),
			.wr_addr_i(update_set_i),
			.wr_data_i(update_tag_i)
		);

		// Valid is set by a fill and cleared by either invalidate
		cache_valid_array #(
			.NUM_SETS(NUM_SETS)
		) valid_mem (
			.clk(clk),
			.reset(reset),
			.rd_en_i(access_i),
			.rd_addr_i(req_set),
			.rd_valid_o(way_valid[w]),
			.wr_en_i(way_wr_en[w]),
			.wr_addr_i(update_set_i),
			.wr_valid_i(update_i)
		);

		assign way_hit[w] = way_valid[w] && (way_tag[w] == req_tag_q);
	end

	// The access strobe qualifies the response in the next cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			access_q <= 1'b0;
		else
			access_q <= access_i;
	end

	// The tag is captured together with the RAM read
	always_ff @(posedge clk)
	begin
		if (access_i)
			req_tag_q <= req_tag;
	end

	// One-hot to index by ORing the indexes of all hitting ways
	// Only meaningful when at most one way hits
	always_comb
	begin
		hit_way_o = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (way_hit[w])
				hit_way_o = hit_way_o | WAY_WIDTH'(w);
		end
	end

	// Stale RAM outputs from an earlier lookup must not show as a hit
	assign cache_hit_o = access_q && (|way_hit);

	// The APB side must never issue two kinds of update in one cycle
	a_one_update: assert property (@(posedge clk) disable iff (reset)
		$onehot0({update_i, inv_way_i, inv_set_i}))
		else $error("l1_cache_tag update pulses overlap %b", {update_i, inv_way_i, inv_set_i});

	// A tag may be present in only one way of a set
	a_one_hit: assert property (@(posedge clk) disable iff (reset)
		access_q |-> $onehot0(way_hit))
		else $error("l1_cache_tag multiple ways hit %h", way_hit);

endmodule

`default_nettype wire

/* src/l1_tag_pkg.sv */
`default_nettype none

package l1_tag_pkg;

	// The tag array is always four-way set associative
	localparam int NUM_WAYS = 4;

	// Width of a way index, enough to name one of NUM_WAYS ways
	localparam int WAY_WIDTH = 2;

	// Defaults for the top level geometry
	// The set and tag widths are derived from these in each module
	localparam int DEF_NUM_SETS = 16;
	localparam int DEF_ADDR_WIDTH = 26;

	// Opcodes accepted by the command register
	// CMD_NONE marks the illegal zero opcode, which the APB slave rejects
	typedef enum logic [1:0] {
		CMD_NONE    = 2'd0,
		CMD_FILL    = 2'd1,
		CMD_INV_WAY = 2'd2,
		CMD_INV_SET = 2'd3
	} tag_cmd_e;

	// APB register map of the update port
	// REG_TAG holds the tag to be written on a fill
	localparam logic [7:0] REG_TAG = 8'h00;

	// REG_LOC holds the set index in its low bits and the way in bits 17:16
	localparam logic [7:0] REG_LOC = 8'h04;

	// Writing REG_CMD starts one update, it always reads as zero
	localparam logic [7:0] REG_CMD = 8'h08;

endpackage

`default_nettype wire

/* src/l1_tag_top.sv */
`default_nettype none
`timescale 1ns/1ns

module l1_tag_top #(
	parameter int NUM_SETS = l1_tag_pkg::DEF_NUM_SETS,
	parameter int ADDR_WIDTH = l1_tag_pkg::DEF_ADDR_WIDTH,
	localparam int SET_WIDTH = $clog2(NUM_SETS),
	localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH
) (
	input logic clk,
	input logic reset,

	// APB update port
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [7:0] paddr_i,
	input logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,

	// Lookup port
	input logic lookup_valid_i,
	input logic [ADDR_WIDTH-1:0] lookup_addr_i,
	output logic hit_o,
	output logic [l1_tag_pkg::WAY_WIDTH-1:0] hit_way_o
);

	// Update command from the APB slave to the tag unit
	logic upd_fill;
	logic upd_inv_way;
	logic upd_inv_set;
	logic [TAG_WIDTH-1:0] upd_tag;
	logic [SET_WIDTH-1:0] upd_set;
	logic [l1_tag_pkg::WAY_WIDTH-1:0] upd_way;

	tag_update_apb #(
		.NUM_SETS(NUM_SETS),
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_apb (
		.clk(clk),
		.reset(reset),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.update_o(upd_fill),
		.inv_way_o(upd_inv_way),
		.inv_set_o(upd_inv_set),
		.update_tag_o(upd_tag),
		.update_set_o(upd_set),
		.update_way_o(upd_way)
	);

	// The tag unit answers every lookup one cycle later
	l1_cache_tag #(
		.NUM_SETS(NUM_SETS),
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_tag (
		.clk(clk),
		.reset(reset),
		.access_i(lookup_valid_i),
		.request_addr_i(lookup_addr_i),
		.cache_hit_o(hit_o),
		.hit_way_o(hit_way_o),
		.update_i(upd_fill),
		.inv_way_i(upd_inv_way),
		.inv_set_i(upd_inv_set),
		.update_way_i(upd_way),
		.update_tag_i(upd_tag),
		.update_set_i(upd_set)
	);

endmodule

`default_nettype wire

/* src/sram_1r1w.sv */
`default_nettype none
`timescale 1ns/1ns

module sram_1r1w #(
	parameter int WIDTH = 24,
	parameter int DEPTH = 16,
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
	input logic clk,
	input logic reset,
	input logic rd_en_i,
	input logic [AW-1:0] rd_addr_i,
	output logic [WIDTH-1:0] rd_data_o,
	input logic wr_en_i,
	input logic [AW-1:0] wr_addr_i,
	input logic [WIDTH-1:0] wr_data_i
);

	// Storage array, mapped to a RAM macro or to flops by synthesis
	logic [WIDTH-1:0] mem [DEPTH];

	// Write port
	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// Read port with registered output
	// Both ports update on the same edge, so a read of the address being
	// written returns the old word (read-first)
	// The output holds its value while rd_en_i is low
	always_ff @(posedge clk)
	begin
		if (rd_en_i)
			rd_data_o <= mem[rd_addr_i];
	end

	// An address past the end would alias when DEPTH is not a power of two
	a_addr_in_range: assert property (@(posedge clk) disable iff (reset)
		(rd_en_i |-> int'(rd_addr_i) < DEPTH) and (wr_en_i |-> int'(wr_addr_i) < DEPTH))
		else $error("sram_1r1w address out of range rd=%h wr=%h", rd_addr_i, wr_addr_i);

endmodule

`default_nettype wire

/* src/tag_update_apb.sv */
`default_nettype none
`timescale 1ns/1ns

module tag_update_apb #(
	parameter int NUM_SETS = l1_tag_pkg::DEF_NUM_SETS,
	parameter int ADDR_WIDTH = l1_tag_pkg::DEF_ADDR_WIDTH,
	localparam int SET_WIDTH = $clog2(NUM_SETS),
	localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH
) (
	input logic clk,
	input logic reset,

	// APB slave
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [7:0] paddr_i,
	input logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,

	// Update command to the tag unit
	output logic update_o,
	output logic inv_way_o,
	output logic inv_set_o,
	output logic [TAG_WIDTH-1:0] update_tag_o,
	output logic [SET_WIDTH-1:0] update_set_o,
	output logic [l1_tag_pkg::WAY_WIDTH-1:0] update_way_o
);

	import l1_tag_pkg::*;

	// Lowest bit of the way field in REG_LOC
	localparam int LOC_WAY_LSB = 16;

	logic access;
	logic sel_tag;
	logic sel_loc;
	logic sel_cmd;
	logic addr_bad;
	logic op_bad;
	logic set_bad;
	logic err;
	logic wr_ok;
	tag_cmd_e cmd;

	// Programmed tag and location
	logic [TAG_WIDTH-1:0] tag_q;
	logic [SET_WIDTH-1:0] set_q;
	logic [WAY_WIDTH-1:0] way_q;

	// APB access phase with no wait states
	assign access = psel_i && penable_i;
	assign pready_o = 1'b1;

	// Register decode
	assign sel_tag = (paddr_i == REG_TAG);
	assign sel_loc = (paddr_i == REG_LOC);
	assign sel_cmd = (paddr_i == REG_CMD);
	assign cmd = tag_cmd_e'(pwdata_i[1:0]);

	// Any one of the error checks blocks the write
	assign addr_bad = !(sel_tag || sel_loc || sel_cmd);
	assign op_bad = pwrite_i && sel_cmd && (cmd == CMD_NONE);
	// The whole 16 bit set field is compared so high garbage is caught too
	assign set_bad = pwrite_i && sel_loc && ({16'h0, pwdata_i[15:0]} >= 32'(NUM_SETS));
	assign err = addr_bad || op_bad || set_bad;

	assign pslverr_o = access && err;
	assign wr_ok = access && pwrite_i && !err;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			tag_q <= '0;
			set_q <= '0;
			way_q <= '0;
		end
		else if (wr_ok)
		begin
			if (sel_tag)
				tag_q <= pwdata_i[TAG_WIDTH-1:0];
			if (sel_loc)
			begin
				set_q <= pwdata_i[SET_WIDTH-1:0];
				way_q <= pwdata_i[LOC_WAY_LSB +: WAY_WIDTH];
			end
		end
	end

	// A good command write becomes a single pulse in the next cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			update_o <= 1'b0;
			inv_way_o <= 1'b0;
			inv_set_o <= 1'b0;
		end
		else
		begin
			update_o <= wr_ok && sel_cmd && (cmd == CMD_FILL);
			inv_way_o <= wr_ok && sel_cmd && (cmd == CMD_INV_WAY);
			inv_set_o <= wr_ok && sel_cmd && (cmd == CMD_INV_SET);
		end
	end

	// Read mux where REG_CMD and unmapped addresses return zero
	always_comb
	begin
		prdata_o = '0;
		if (sel_tag)
		begin
			prdata_o[TAG_WIDTH-1:0] = tag_q;
		end
		else if (sel_loc)
		begin
			prdata_o[SET_WIDTH-1:0] = set_q;
			prdata_o[LOC_WAY_LSB +: WAY_WIDTH] = way_q;
		end
	end

	assign update_tag_o = tag_q;
	assign update_set_o = set_q;
	assign update_way_o = way_q;

	// Every command needs a setup and an access cycle on APB, so pulses never come back to back
	a_pulse_single: assert property (@(posedge clk) disable iff (reset)
		(update_o || inv_way_o || inv_set_o)
		|=> !(update_o || inv_way_o || inv_set_o))
		else $error("tag_update_apb back to back pulses %b", {update_o, inv_way_o, inv_set_o});

endmodule

`default_nettype wire

/* tb.f */
src/l1_tag_pkg.sv
src/sram_1r1w.sv
src/cache_valid_array.sv
src/l1_cache_tag.sv
src/tag_update_apb.sv
src/l1_tag_top.sv
dv/tb_l1_tag.sv
